// File: hdl/code_builder.sv
`timescale 1ns/1ps

module code_builder (
	input  logic                                                    clk,
	input  logic                                                    reset,
	input  logic                                                    merge_load,
	input  logic                                                    split_en,
	input  logic [huffman_pkg::NUM_ROUNDS*huffman_pkg::MASK_W-1:0]  pair_hi_mask,
	input  logic [huffman_pkg::NUM_ROUNDS*huffman_pkg::MASK_W-1:0]  pair_lo_mask,
	output logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::CODE_W-1:0] hc,
	output logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::CODE_W-1:0] m
);
	import huffman_pkg::*;

	logic [2:0]        rd_ptr;
	logic [MASK_W-1:0] one_mask;
	logic [MASK_W-1:0] zero_mask;

	assign one_mask = pair_hi_mask[rd_ptr*MASK_W +: MASK_W];
	assign zero_mask = pair_lo_mask[rd_ptr*MASK_W +: MASK_W];

	// walk from the root round down to the first round
	always_ff @(posedge clk) begin
		if (reset)
			rd_ptr <= '0;
		else if (merge_load)
			rd_ptr <= 3'(NUM_ROUNDS - 1);
		else if (split_en && rd_ptr != '0)
			rd_ptr <= rd_ptr - 3'd1;
	end

	// each level shifts one code bit in at the low end
	always_ff @(posedge clk) begin
		if (reset) begin
			hc <= '0;
			m <= '0;
		end else if (split_en) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (one_mask[s] || zero_mask[s]) begin
					hc[s*CODE_W +: CODE_W] <= {hc[s*CODE_W +: CODE_W-1], one_mask[s]};
					m[s*CODE_W +: CODE_W] <= {m[s*CODE_W +: CODE_W-1], 1'b1};
				end
			end
		end
	end

endmodule

// File: hdl/huffman_ctrl.sv
`timescale 1ns/1ps

module huffman_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic gray_valid,
	output logic count_en,
	output logic sort_load,
	output logic sort_en,
	output logic merge_load,
	output logic merge_en,
	output logic split_en,
	output logic cnt_valid,
	output logic code_valid
);
	import huffman_pkg::*;

	logic [2:0] phase;
	logic [2:0] phase_next;
	logic [2:0] step;
	logic       step_last;

	// end of the fixed-length phases
	always_comb begin
		case (phase)
			PH_SORT:  step_last = (step == 3'(SORT_PASSES - 1));
			PH_MERGE: step_last = (step == 3'(NUM_ROUNDS - 1));
			PH_SPLIT: step_last = (step == 3'(NUM_ROUNDS - 1));
			default:  step_last = 1'b0;
		endcase
	end

	always_comb begin
		case (phase)
			PH_IDLE:      phase_next = gray_valid ? PH_RECEIVE : PH_IDLE;
			PH_RECEIVE:   phase_next = gray_valid ? PH_RECEIVE : PH_COUNT_OUT;
			PH_COUNT_OUT: phase_next = PH_SORT;
			PH_SORT:      phase_next = step_last ? PH_LOAD : PH_SORT;
			PH_LOAD:      phase_next = PH_MERGE;
			PH_MERGE:     phase_next = step_last ? PH_SPLIT : PH_MERGE;
			PH_SPLIT:     phase_next = step_last ? PH_DONE : PH_SPLIT;
			// results held until reset
			default:      phase_next = PH_DONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			step <= '0;
			code_valid <= 1'b0;
		end else begin
			phase <= phase_next;
			// step restarts with every phase change
			if (phase_next != phase)
				step <= '0;
			else if (phase == PH_SORT || phase == PH_MERGE || phase == PH_SPLIT)
				step <= step + 3'd1;
			if (phase == PH_SPLIT && step_last)
				code_valid <= 1'b1;
		end
	end

	// strobes straight from the phase
	assign count_en   = (phase == PH_IDLE) || (phase == PH_RECEIVE);
	assign sort_load  = (phase == PH_COUNT_OUT);
	assign sort_en    = (phase == PH_SORT);
	assign merge_load = (phase == PH_LOAD);
	assign merge_en   = (phase == PH_MERGE);
	assign split_en   = (phase == PH_SPLIT);
	assign cnt_valid  = (phase == PH_COUNT_OUT);

endmodule

// File: hdl/huffman_pkg.sv
package huffman_pkg;

	// ==================================================
	// symbol set and word widths
	// ==================================================
	localparam int NUM_SYMBOLS = 6;
	// one mask bit per symbol, bit k-1 is symbol k
	localparam int MASK_W      = 6;
	localparam int CODE_W      = 8;
	localparam int NUM_ROUNDS  = NUM_SYMBOLS - 1;
	localparam int SORT_PASSES = NUM_SYMBOLS;

	// ==================================================
	// control phases
	// ==================================================
	localparam logic [2:0] PH_IDLE      = 3'd0;
	localparam logic [2:0] PH_RECEIVE   = 3'd1;
	localparam logic [2:0] PH_COUNT_OUT = 3'd2;
	localparam logic [2:0] PH_SORT      = 3'd3;
	localparam logic [2:0] PH_LOAD      = 3'd4;
	localparam logic [2:0] PH_MERGE     = 3'd5;
	localparam logic [2:0] PH_SPLIT     = 3'd6;
	localparam logic [2:0] PH_DONE      = 3'd7;

endpackage

// File: hdl/huffman_top.sv
`timescale 1ns/1ps

module huffman_top #(
	parameter int COUNT_W = 8
) (
	input  logic                                                    clk,
	input  logic                                                    reset,
	input  logic                                                    gray_valid,
	input  logic [7:0]                                              gray_data,
	output logic                                                    cnt_valid,
	output logic [huffman_pkg::NUM_SYMBOLS*COUNT_W-1:0]              cnt,
	output logic                                                    code_valid,
	output logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::CODE_W-1:0] hc,
	output logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::CODE_W-1:0] m
);
	import huffman_pkg::*;

	logic                                count_en;
	logic                                sort_load;
	logic                                sort_en;
	logic                                merge_load;
	logic                                merge_en;
	logic                                split_en;
	logic [NUM_SYMBOLS*(COUNT_W+3)-1:0]  sorted_cnt;
	logic [NUM_SYMBOLS*MASK_W-1:0]       sorted_mask;
	logic [NUM_ROUNDS*MASK_W-1:0]        pair_hi_mask;
	logic [NUM_ROUNDS*MASK_W-1:0]        pair_lo_mask;

	huffman_ctrl u_ctrl (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.count_en   (count_en),
		.sort_load  (sort_load),
		.sort_en    (sort_en),
		.merge_load (merge_load),
		.merge_en   (merge_en),
		.split_en   (split_en),
		.cnt_valid  (cnt_valid),
		.code_valid (code_valid)
	);

	symbol_counter #(.COUNT_W(COUNT_W)) u_counter (
		.clk        (clk),
		.reset      (reset),
		.count_en   (count_en),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt        (cnt)
	);

	node_sorter #(.COUNT_W(COUNT_W)) u_sorter (
		.clk         (clk),
		.reset       (reset),
		.sort_load   (sort_load),
		.sort_en     (sort_en),
		.cnt         (cnt),
		.sorted_cnt  (sorted_cnt),
		.sorted_mask (sorted_mask)
	);

	merge_engine #(.COUNT_W(COUNT_W)) u_merge (
		.clk          (clk),
		.reset        (reset),
		.merge_load   (merge_load),
		.merge_en     (merge_en),
		.sorted_cnt   (sorted_cnt),
		.sorted_mask  (sorted_mask),
		.pair_hi_mask (pair_hi_mask),
		.pair_lo_mask (pair_lo_mask)
	);

	code_builder u_builder (
		.clk          (clk),
		.reset        (reset),
		.merge_load   (merge_load),
		.split_en     (split_en),
		.pair_hi_mask (pair_hi_mask),
		.pair_lo_mask (pair_lo_mask),
		.hc           (hc),
		.m            (m)
	);

endmodule

// File: hdl/merge_engine.sv
`timescale 1ns/1ps

module merge_engine #(
	parameter int COUNT_W = 8
) (
	input  logic                                             clk,
	input  logic                                             reset,
	input  logic                                             merge_load,
	input  logic                                             merge_en,
	input  logic [huffman_pkg::NUM_SYMBOLS*(COUNT_W+3)-1:0]   sorted_cnt,
	input  logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::MASK_W-1:0] sorted_mask,
	output logic [huffman_pkg::NUM_ROUNDS*huffman_pkg::MASK_W-1:0]  pair_hi_mask,
	output logic [huffman_pkg::NUM_ROUNDS*huffman_pkg::MASK_W-1:0]  pair_lo_mask
);
	import huffman_pkg::*;

	localparam int NODE_W = COUNT_W + 3;

	logic [NODE_W-1:0] cnt_q    [NUM_SYMBOLS];
	logic [MASK_W-1:0] mask_q   [NUM_SYMBOLS];
	// list padded with two filler slots
	logic [NODE_W-1:0] ext_cnt  [NUM_SYMBOLS+2];
	logic [MASK_W-1:0] ext_mask [NUM_SYMBOLS+2];
	logic [NODE_W-1:0] nxt_cnt  [NUM_SYMBOLS];
	logic [MASK_W-1:0] nxt_mask [NUM_SYMBOLS];
	logic [NODE_W-1:0] sum_cnt;
	logic [MASK_W-1:0] sum_mask;
	logic [2:0]        ins_pos;
	logic [2:0]        round_ptr;
	logic [MASK_W-1:0] hi_q     [NUM_ROUNDS];
	logic [MASK_W-1:0] lo_q     [NUM_ROUNDS];

	function automatic logic precedes(input logic [NODE_W-1:0] a_cnt,
		input logic [MASK_W-1:0] a_mask, input logic [NODE_W-1:0] b_cnt,
		input logic [MASK_W-1:0] b_mask);
		return (a_cnt < b_cnt) || ((a_cnt == b_cnt) && (a_mask > b_mask));
	endfunction

	assign sum_cnt = cnt_q[0] + cnt_q[1];
	assign sum_mask = mask_q[0] | mask_q[1];

	// ==================================================
	// rebuild: drop the front pair, insert the merged node
	// ==================================================
	always_comb begin
		for (int k = 0; k < NUM_SYMBOLS + 2; k++) begin
			// filler sorts behind every real node
			ext_cnt[k] = '1;
			ext_mask[k] = '0;
		end
		for (int k = 0; k < NUM_SYMBOLS; k++) begin
			ext_cnt[k] = cnt_q[k];
			ext_mask[k] = mask_q[k];
		end
		ins_pos = '0;
		for (int k = 2; k < NUM_SYMBOLS; k++) begin
			if (precedes(cnt_q[k], mask_q[k], sum_cnt, sum_mask))
				ins_pos = ins_pos + 3'd1;
		end
		for (int j = 0; j < NUM_SYMBOLS; j++) begin
			if (3'(j) < ins_pos) begin
				nxt_cnt[j] = ext_cnt[j+2];
				nxt_mask[j] = ext_mask[j+2];
			end else if (3'(j) == ins_pos) begin
				nxt_cnt[j] = sum_cnt;
				nxt_mask[j] = sum_mask;
			end else begin
				nxt_cnt[j] = ext_cnt[j+1];
				nxt_mask[j] = ext_mask[j+1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (merge_load) begin
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				cnt_q[i] <= sorted_cnt[i*NODE_W +: NODE_W];
				mask_q[i] <= sorted_mask[i*MASK_W +: MASK_W];
			end
		end else if (merge_en) begin
			cnt_q <= nxt_cnt;
			mask_q <= nxt_mask;
			// front slot takes the 1 branch
			hi_q[round_ptr] <= mask_q[0];
			lo_q[round_ptr] <= mask_q[1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset || merge_load)
			round_ptr <= '0;
		else if (merge_en)
			round_ptr <= round_ptr + 3'd1;
	end

	for (genvar g = 0; g < NUM_ROUNDS; g++) begin : g_flat
		assign pair_hi_mask[g*MASK_W +: MASK_W] = hi_q[g];
		assign pair_lo_mask[g*MASK_W +: MASK_W] = lo_q[g];
	end

endmodule

// File: hdl/node_sorter.sv
`timescale 1ns/1ps

module node_sorter #(
	parameter int COUNT_W = 8
) (
	input  logic                                             clk,
	input  logic                                             reset,
	input  logic                                             sort_load,
	input  logic                                             sort_en,
	input  logic [huffman_pkg::NUM_SYMBOLS*COUNT_W-1:0]       cnt,
	output logic [huffman_pkg::NUM_SYMBOLS*(COUNT_W+3)-1:0]   sorted_cnt,
	output logic [huffman_pkg::NUM_SYMBOLS*huffman_pkg::MASK_W-1:0] sorted_mask
);
	import huffman_pkg::*;

	localparam int NODE_W = COUNT_W + 3;

	logic [NODE_W-1:0] cnt_q    [NUM_SYMBOLS];
	logic [MASK_W-1:0] mask_q   [NUM_SYMBOLS];
	logic [NODE_W-1:0] nxt_cnt  [NUM_SYMBOLS];
	logic [MASK_W-1:0] nxt_mask [NUM_SYMBOLS];
	logic              odd_pass;

	// smaller count first, on a tie the larger mask first
	function automatic logic precedes(input logic [NODE_W-1:0] a_cnt,
		input logic [MASK_W-1:0] a_mask, input logic [NODE_W-1:0] b_cnt,
		input logic [MASK_W-1:0] b_mask);
		return (a_cnt < b_cnt) || ((a_cnt == b_cnt) && (a_mask > b_mask));
	endfunction

	// one transposition pass, even pairs then odd pairs
	always_comb begin
		nxt_cnt = cnt_q;
		nxt_mask = mask_q;
		for (int i = 0; i < NUM_SYMBOLS - 1; i++) begin
			if (i[0] == odd_pass && precedes(cnt_q[i+1], mask_q[i+1], cnt_q[i], mask_q[i])) begin
				nxt_cnt[i] = cnt_q[i+1];
				nxt_mask[i] = mask_q[i+1];
				nxt_cnt[i+1] = cnt_q[i];
				nxt_mask[i+1] = mask_q[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sort_load) begin
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				cnt_q[i] <= NODE_W'(cnt[i*COUNT_W +: COUNT_W]);
				mask_q[i] <= MASK_W'(1) << i;
			end
		end else if (sort_en) begin
			cnt_q <= nxt_cnt;
			mask_q <= nxt_mask;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || sort_load)
			odd_pass <= 1'b0;
		else if (sort_en)
			odd_pass <= ~odd_pass;
	end

	for (genvar g = 0; g < NUM_SYMBOLS; g++) begin : g_flat
		assign sorted_cnt[g*NODE_W +: NODE_W] = cnt_q[g];
		assign sorted_mask[g*MASK_W +: MASK_W] = mask_q[g];
	end

endmodule

// File: hdl/symbol_counter.sv
`timescale 1ns/1ps

module symbol_counter #(
	parameter int COUNT_W = 8
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       count_en,
	input  logic                                       gray_valid,
	input  logic [7:0]                                 gray_data,
	output logic [huffman_pkg::NUM_SYMBOLS*COUNT_W-1:0] cnt
);
	import huffman_pkg::*;

	// one counter per symbol, values outside 1..6 match none
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (count_en && gray_valid) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				// hold at all ones
				if (gray_data == 8'(s + 1) && cnt[s*COUNT_W +: COUNT_W] != {COUNT_W{1'b1}})
					cnt[s*COUNT_W +: COUNT_W] <= cnt[s*COUNT_W +: COUNT_W] + COUNT_W'(1);
			end
		end
	end

endmodule

// File: project.f
hdl/huffman_pkg.sv
hdl/huffman_ctrl.sv
hdl/symbol_counter.sv
hdl/node_sorter.sv
hdl/merge_engine.sv
hdl/code_builder.sv
hdl/huffman_top.sv
testbench/tb_huffman.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the Huffman encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_huffman -f project.f -o sim_huffman
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_huffman
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

// File: testbench/tb_huffman.sv
`timescale 1ns/1ps

module tb_huffman;
	import huffman_pkg::*;

	localparam int COUNT_W         = 8;
	localparam int CLK_PERIOD      = 100;
	localparam int MAX_BURST_LEN   = 64;
	// ten checked bursts plus the ignored second burst
	localparam int NUM_BURSTS      = 11;
	localparam int WATCHDOG_CYCLES = NUM_BURSTS * (MAX_BURST_LEN + 40);

	logic                           clk = 1'b0;
	logic                           reset = 1'b1;
	logic                           gray_valid = 1'b0;
	logic [7:0]                     gray_data = 8'd0;
	logic                           cnt_valid;
	logic [NUM_SYMBOLS*COUNT_W-1:0] cnt;
	logic                           code_valid;
	logic [NUM_SYMBOLS*CODE_W-1:0]  hc;
	logic [NUM_SYMBOLS*CODE_W-1:0]  m;

	logic [7:0]  burst_q[$];
	int          tally[NUM_SYMBOLS];
	logic [31:0] rng_state = 32'haf23;

	huffman_top #(.COUNT_W(COUNT_W)) u_huffman_top (
		.clk        (clk),
		.reset      (reset),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.cnt        (cnt),
		.code_valid (code_valid),
		.hc         (hc),
		.m          (m)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==================================================
	// helpers
	// ==================================================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// smaller count first, equal counts by the larger mask
	function automatic bit comes_first(input int a_cnt, input int a_mask, input int b_cnt,
		input int b_mask);
		return (a_cnt < b_cnt) || ((a_cnt == b_cnt) && (a_mask > b_mask));
	endfunction

	// round-robin burst, one 8-bit wanted count per symbol
	task automatic queue_counts(input logic [47:0] want);
		int left[NUM_SYMBOLS];
		bit more;
		burst_q.delete();
		for (int s = 0; s < NUM_SYMBOLS; s++)
			left[s] = int'(want[s*8 +: 8]);
		more = 1'b1;
		while (more) begin
			more = 1'b0;
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (left[s] > 0) begin
					burst_q.push_back(8'(s + 1));
					left[s]--;
					more = 1'b1;
				end
			end
		end
	endtask

	task automatic tally_burst();
		for (int s = 0; s < NUM_SYMBOLS; s++)
			tally[s] = 0;
		foreach (burst_q[i]) begin
			if (burst_q[i] >= 8'd1 && burst_q[i] <= 8'd6)
				tally[int'(burst_q[i]) - 1]++;
		end
	endtask

	// ==================================================
	// reference model on the tallied counts
	// ==================================================
	task automatic reference_codes(output logic [NUM_SYMBOLS*CODE_W-1:0] ref_hc,
		output logic [NUM_SYMBOLS*CODE_W-1:0] ref_m);
		int         lc[NUM_SYMBOLS];
		int         lm[NUM_SYMBOLS];
		logic [5:0] one_m[NUM_ROUNDS];
		logic [5:0] zero_m[NUM_ROUNDS];
		int         n;
		int         pos;
		int         tc;
		int         tm;
		for (int i = 0; i < NUM_SYMBOLS; i++) begin
			lc[i] = tally[i];
			lm[i] = 1 << i;
		end
		// insertion sort of the leaves
		for (int i = 1; i < NUM_SYMBOLS; i++) begin
			tc = lc[i];
			tm = lm[i];
			pos = i;
			while (pos > 0 && comes_first(tc, tm, lc[pos-1], lm[pos-1])) begin
				lc[pos] = lc[pos-1];
				lm[pos] = lm[pos-1];
				pos--;
			end
			lc[pos] = tc;
			lm[pos] = tm;
		end
		n = NUM_SYMBOLS;
		for (int r = 0; r < NUM_ROUNDS; r++) begin
			one_m[r] = 6'(lm[0]);
			zero_m[r] = 6'(lm[1]);
			tc = lc[0] + lc[1];
			tm = lm[0] | lm[1];
			for (int k = 2; k < n; k++) begin
				lc[k-2] = lc[k];
				lm[k-2] = lm[k];
			end
			n = n - 2;
			pos = 0;
			while (pos < n && comes_first(lc[pos], lm[pos], tc, tm))
				pos++;
			for (int k = n; k > pos; k--) begin
				lc[k] = lc[k-1];
				lm[k] = lm[k-1];
			end
			lc[pos] = tc;
			lm[pos] = tm;
			n++;
		end
		ref_hc = '0;
		ref_m = '0;
		// root round first, so its bit ends up on top
		for (int r = NUM_ROUNDS - 1; r >= 0; r--) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (one_m[r][s] || zero_m[r][s]) begin
					ref_hc[s*CODE_W +: CODE_W] = {ref_hc[s*CODE_W +: CODE_W-1], one_m[r][s]};
					ref_m[s*CODE_W +: CODE_W] = {ref_m[s*CODE_W +: CODE_W-1], 1'b1};
				end
			end
		end
	endtask

	// ==================================================
	// stimulus and response checks
	// ==================================================
	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		gray_valid <= 1'b0;
		gray_data <= 8'd0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic drive_burst();
		foreach (burst_q[i]) begin
			@(posedge clk);
			gray_valid <= 1'b1;
			gray_data <= burst_q[i];
		end
		@(posedge clk);
		gray_valid <= 1'b0;
		gray_data <= 8'd0;
	endtask

	task automatic check_counts();
		logic [NUM_SYMBOLS*COUNT_W-1:0] exp_cnt;
		int waited;
		exp_cnt = '0;
		for (int s = 0; s < NUM_SYMBOLS; s++)
			exp_cnt[s*COUNT_W +: COUNT_W] = COUNT_W'(tally[s]);
		waited = 0;
		@(negedge clk);
		while (!cnt_valid && waited < 8) begin
			waited++;
			@(negedge clk);
		end
		if (waited != 1)
			abort_run($sformatf("cnt_valid came %0d cycles after the burst end, not 1", waited));
		check_value("cnt", 64'(cnt), 64'(exp_cnt));
		@(negedge clk);
		if (cnt_valid)
			abort_run("cnt_valid stayed high for more than one cycle");
	endtask

	task automatic check_codes();
		logic [NUM_SYMBOLS*CODE_W-1:0] ref_hc;
		logic [NUM_SYMBOLS*CODE_W-1:0] ref_m;
		int waited;
		// one cycle already passed since the cnt_valid cycle
		waited = 1;
		while (!code_valid && waited < 40) begin
			@(negedge clk);
			waited++;
		end
		if (waited != 18)
			abort_run($sformatf("code_valid rose %0d cycles after cnt_valid, not 18", waited));
		reference_codes(ref_hc, ref_m);
		check_value("hc", 64'(hc), 64'(ref_hc));
		check_value("m", 64'(m), 64'(ref_m));
	endtask

	task automatic run_burst();
		tally_burst();
		apply_reset();
		drive_burst();
		check_counts();
		check_codes();
	endtask

	// ==================================================
	// tests
	// ==================================================
	task automatic test_distinct_counts();
		queue_counts(48'h04_02_08_03_01_05);
		run_burst();
	endtask

	task automatic test_invalid_values();
		queue_counts(48'h03_01_02_06_04_07);
		burst_q.insert(0, 8'd0);
		burst_q.insert(5, 8'd7);
		burst_q.insert(12, 8'd255);
		burst_q.push_back(8'd7);
		run_burst();
	endtask

	task automatic test_equal_counts();
		queue_counts(48'h02_02_02_02_02_02);
		run_burst();
		// worked by hand, lengths 2,2,3,3,3,3
		check_value("hc", 64'(hc), 64'h0302_0100_0302);
		check_value("m", 64'(m), 64'h0707_0707_0303);
	endtask

	task automatic test_tied_pairs();
		queue_counts(48'h02_06_01_03_01_03);
		run_burst();
	endtask

	task automatic test_random_bursts();
		int         extra;
		logic [7:0] sym;
		repeat (5) begin
			burst_q.delete();
			for (int s = 1; s <= NUM_SYMBOLS; s++)
				burst_q.push_back(8'(s));
			rng_state = xorshift(rng_state);
			extra = int'(rng_state % 32'd55);
			for (int i = 0; i < extra; i++) begin
				rng_state = xorshift(rng_state);
				sym = 8'(rng_state % 32'(NUM_SYMBOLS) + 32'd1);
				rng_state = xorshift(rng_state);
				burst_q.insert(int'(rng_state % 32'(burst_q.size() + 1)), sym);
			end
			run_burst();
		end
	endtask

	task automatic test_second_burst_ignored();
		logic [NUM_SYMBOLS*COUNT_W-1:0] held_cnt;
		logic [NUM_SYMBOLS*CODE_W-1:0]  held_hc;
		logic [NUM_SYMBOLS*CODE_W-1:0]  held_m;
		queue_counts(48'h01_04_02_05_03_06);
		run_burst();
		held_cnt = cnt;
		held_hc = hc;
		held_m = m;
		// results are held, this burst must not count
		queue_counts(48'h05_01_01_01_01_01);
		drive_burst();
		repeat (30) begin
			@(negedge clk);
			if (cnt_valid)
				abort_run("cnt_valid pulsed again for a second burst");
			check_value("code_valid", 64'(code_valid), 64'd1);
		end
		check_value("cnt", 64'(cnt), 64'(held_cnt));
		check_value("hc", 64'(hc), 64'(held_hc));
		check_value("m", 64'(m), 64'(held_m));
		apply_reset();
		@(negedge clk);
		check_value("cnt", 64'(cnt), 64'd0);
		check_value("hc", 64'(hc), 64'd0);
		check_value("m", 64'(m), 64'd0);
		check_value("cnt_valid", 64'(cnt_valid), 64'd0);
		check_value("code_valid", 64'(code_valid), 64'd0);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout: the watchdog expired before all tests finished");
	end

	initial begin
		test_distinct_counts();
		test_invalid_values();
		test_equal_counts();
		test_tied_pairs();
		test_random_bursts();
		test_second_burst_ignored();
		$display(">>> PASS");
		$finish;
	end

endmodule
